//--- source/replica_pkg.sv
package replica_pkg;

    // ****************************************
    // Tour packing
    // ****************************************

    localparam int city_bits       = 7;                          // Up to 128 cities.
    localparam int cities_per_word = 8;
    localparam int offset_bits     = $clog2(cities_per_word);    // Slot within a word.

    typedef logic [city_bits-1:0] city_t;

    // Tour position of the move points K and L.
    typedef logic [city_bits-1:0] pos_t;

    // Element i holds tour position 8*word+i.
    typedef city_t [cities_per_word-1:0] route_word_t;

    // ****************************************
    // Pass commands
    // ****************************************

    typedef enum logic [1:0] {
        NOP = 2'd0,
        THR = 2'd1,    // Tour passes through unchanged.
        OR0 = 2'd2     // Or-opt move of the city at K to L.
    } command_t;

endpackage

//--- source/move_dispatch.sv
`timescale 1ns/1ns

module move_dispatch #(
    parameter  int NUM_REPLICAS = 4,
    localparam int RW           = (NUM_REPLICAS > 1) ? $clog2(NUM_REPLICAS) : 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  move_i,
    input  logic [RW-1:0]         move_replica_i,
    input  replica_pkg::command_t move_command_i,
    input  replica_pkg::pos_t     move_k_i,
    input  replica_pkg::pos_t     move_l_i,
    input  logic [NUM_REPLICAS-1:0] lane_busy_i,
    output replica_pkg::command_t lane_command_o [NUM_REPLICAS],
    output replica_pkg::command_t opt_command_o  [NUM_REPLICAS],
    output replica_pkg::pos_t     opt_k_o        [NUM_REPLICAS],
    output replica_pkg::pos_t     opt_l_o        [NUM_REPLICAS]
);

    logic [NUM_REPLICAS-1:0] accept;

    // A move is taken only by an idle lane and only with a real command.
    always_comb begin
        for (int g = 0; g < NUM_REPLICAS; g++) begin
            accept[g] = move_i
                     && (move_replica_i == RW'(g))
                     && !lane_busy_i[g]
                     && (move_command_i != replica_pkg::NOP);
        end
    end

    // ****************************************
    // Command pulse and held options
    // ****************************************

    always_ff @(posedge clk) begin
        for (int g = 0; g < NUM_REPLICAS; g++) begin
            if (reset) begin
                lane_command_o[g] <= replica_pkg::NOP;
                opt_command_o[g]  <= replica_pkg::NOP;
            end else begin
                lane_command_o[g] <= accept[g] ? move_command_i : replica_pkg::NOP;  // One cycle.
                if (accept[g]) begin
                    opt_command_o[g] <= move_command_i;
                end
            end
        end
    end

    // K and L stay put until the next move to the same lane.
    always_ff @(posedge clk) begin
        for (int g = 0; g < NUM_REPLICAS; g++) begin
            if (accept[g]) begin
                opt_k_o[g] <= move_k_i;
                opt_l_o[g] <= move_l_i;
            end
        end
    end

endmodule

//--- source/route_store.sv
`timescale 1ns/1ns

module route_store #(
    parameter  int CITY_NUM = 64,
    localparam int WORDS    = CITY_NUM / replica_pkg::cities_per_word,
    localparam int AW       = (WORDS > 1) ? $clog2(WORDS) : 1
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [AW-1:0]            rd_addr_i,
    output replica_pkg::route_word_t rd_data_o,
    input  logic                     wr_i,
    input  logic [AW-1:0]            wr_addr_i,
    input  replica_pkg::route_word_t wr_data_i,
    input  logic [AW-1:0]            host_rd_addr_i,
    output replica_pkg::route_word_t host_rd_data_o
);

    replica_pkg::route_word_t mem [WORDS];

    // ****************************************
    // Write port
    // ****************************************

    always_ff @(posedge clk) begin
        if (wr_i && !reset) begin
            mem[wr_addr_i] <= wr_data_i;    // Pass results or host loads.
        end
    end

    // ****************************************
    // Registered read ports
    // ****************************************

    // Pass read lags the address by one cycle.
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

    always_ff @(posedge clk) begin
        host_rd_data_o <= mem[host_rd_addr_i];    // Host readback.
    end

endmodule

//--- source/opt_route.sv
`timescale 1ns/1ns

module opt_route #(
    parameter  int CITY_NUM = 64,
    localparam int WORDS    = CITY_NUM / replica_pkg::cities_per_word,
    localparam int AW       = (WORDS > 1) ? $clog2(WORDS) : 1
) (
    input  logic                     clk,
    input  logic                     reset,
    input  replica_pkg::command_t    command_i,
    input  logic                     command_nop_d_i,
    input  replica_pkg::command_t    opt_command_i,
    input  replica_pkg::pos_t        opt_k_i,
    input  replica_pkg::pos_t        opt_l_i,
    output logic [AW-1:0]            rcount_o,
    input  replica_pkg::route_word_t out_data_i,
    output logic                     out_valid_o,
    output replica_pkg::route_word_t out_data_o
);

    localparam int CPW = replica_pkg::cities_per_word;
    localparam int OW  = replica_pkg::offset_bits;

    logic [AW-1:0]            dcount;
    logic [AW-1:0]            rcount_next;
    logic                     active;
    logic                     is_or0;
    logic                     at_k_word;
    replica_pkg::pos_t        d_word;
    replica_pkg::pos_t        k_word;
    replica_pkg::pos_t        l_word;
    logic [OW-1:0]            k_off;
    logic [OW-1:0]            l_off;
    logic [OW-1:0]            sel [CPW];
    logic [CPW-1:0]           hold;
    logic [CPW-1:0]           ins;
    replica_pkg::city_t       moved;
    replica_pkg::city_t       cap;
    replica_pkg::route_word_t cur;
    replica_pkg::route_word_t pend;
    logic [CPW-1:0]           pend_hold;
    logic                     pend_full;

    assign d_word    = replica_pkg::pos_t'(dcount);
    assign k_word    = opt_k_i >> OW;
    assign l_word    = opt_l_i >> OW;
    assign k_off     = opt_k_i[OW-1:0];
    assign l_off     = opt_l_i[OW-1:0];
    assign is_or0    = (opt_command_i == replica_pkg::OR0);
    assign at_k_word = is_or0 && (d_word == k_word);
    assign active    = !command_nop_d_i || (dcount != '0);    // Word dcount is on out_data_i.

    // ****************************************
    // Source select and hold mask
    // ****************************************

    always_comb begin
        logic after_k;
        logic before_l;
        for (int j = 0; j < CPW; j++) begin
            after_k  = (d_word > k_word) || ((d_word == k_word) && (j >= k_off));
            before_l = (d_word < l_word) || ((d_word == l_word) && (j < l_off));
            sel[j]   = OW'(j);
            hold[j]  = 1'b0;
            ins[j]   = 1'b0;
            if (is_or0 && after_k && before_l) begin    // Position takes its right neighbour.
                if (j < CPW - 1) begin
                    sel[j] = OW'(j + 1);
                end else begin
                    hold[j] = 1'b1;    // Neighbour is slot 0 of the next word.
                end
            end
            if (is_or0 && (d_word == l_word) && (j == l_off)) begin
                ins[j] = 1'b1;
            end
        end
    end

    // The moved city comes straight from the input when K and L share the word.
    assign moved = at_k_word ? out_data_i[k_off] : cap;

    always_comb begin
        for (int j = 0; j < CPW; j++) begin
            cur[j] = ins[j] ? moved : out_data_i[sel[j]];
        end
    end

    // ****************************************
    // Output stage
    // ****************************************

    always_ff @(posedge clk) begin
        if (active && at_k_word) begin
            cap <= out_data_i[k_off];
        end
        if (active) begin
            pend      <= cur;
            pend_hold <= hold;
        end
        if (pend_full) begin
            for (int j = 0; j < CPW; j++) begin
                out_data_o[j] <= pend_hold[j] ? out_data_i[0] : pend[j];
            end
        end else begin
            out_data_o <= cur;
        end
    end

    // From the word at K/8 on, every word leaves one cycle late.
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_full   <= 1'b0;
            out_valid_o <= 1'b0;
        end else if (active) begin
            out_valid_o <= pend_full || !at_k_word;
            pend_full   <= pend_full || at_k_word;
        end else begin
            out_valid_o <= pend_full;    // Flush of the last word.
            pend_full   <= 1'b0;
        end
    end

    // ****************************************
    // Word counters
    // ****************************************

    assign rcount_next = (rcount_o == AW'(WORDS - 1)) ? '0 : rcount_o + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            rcount_o <= '0;
            dcount   <= '0;
        end else begin
            if ((command_i != replica_pkg::NOP) || (rcount_o != '0)) begin
                rcount_o <= rcount_next;
            end
            dcount <= rcount_o;
        end
    end

endmodule

//--- source/route_lane.sv
`timescale 1ns/1ns

module route_lane #(
    parameter  int CITY_NUM = 64,
    localparam int WORDS    = CITY_NUM / replica_pkg::cities_per_word,
    localparam int AW       = (WORDS > 1) ? $clog2(WORDS) : 1
) (
    input  logic                     clk,
    input  logic                     reset,
    input  replica_pkg::command_t    lane_command_i,
    input  replica_pkg::command_t    opt_command_i,
    input  replica_pkg::pos_t        opt_k_i,
    input  replica_pkg::pos_t        opt_l_i,
    input  logic                     load_i,
    input  logic [AW-1:0]            load_addr_i,
    input  replica_pkg::route_word_t load_data_i,
    input  logic [AW-1:0]            host_rd_addr_i,
    output logic                     busy_o,
    output logic                     done_o,
    output replica_pkg::route_word_t host_rd_data_o
);

    logic [AW-1:0]            rcount;
    logic [AW-1:0]            wptr;
    logic [AW-1:0]            wr_addr;
    logic                     command_nop_d;
    logic                     out_valid;
    logic                     last_wr;
    logic                     busy_r;
    logic                     wr;
    replica_pkg::route_word_t rd_data;
    replica_pkg::route_word_t out_data;
    replica_pkg::route_word_t wr_data;

    route_store #(
        .CITY_NUM (CITY_NUM)
    ) u_store (
        .clk            (clk),
        .reset          (reset),
        .rd_addr_i      (rcount),
        .rd_data_o      (rd_data),
        .wr_i           (wr),
        .wr_addr_i      (wr_addr),
        .wr_data_i      (wr_data),
        .host_rd_addr_i (host_rd_addr_i),
        .host_rd_data_o (host_rd_data_o)
    );

    opt_route #(
        .CITY_NUM (CITY_NUM)
    ) u_opt (
        .clk             (clk),
        .reset           (reset),
        .command_i       (lane_command_i),
        .command_nop_d_i (command_nop_d),
        .opt_command_i   (opt_command_i),
        .opt_k_i         (opt_k_i),
        .opt_l_i         (opt_l_i),
        .rcount_o        (rcount),
        .out_data_i      (rd_data),
        .out_valid_o     (out_valid),
        .out_data_o      (out_data)
    );

    // Host loads share the write port; they only come while the lane is idle.
    assign wr      = load_i || out_valid;
    assign wr_addr = load_i ? load_addr_i : wptr;
    assign wr_data = load_i ? load_data_i : out_data;

    assign last_wr = out_valid && (wptr == AW'(WORDS - 1));
    assign busy_o  = busy_r || (lane_command_i != replica_pkg::NOP);

    // ****************************************
    // Pass sequencing
    // ****************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            command_nop_d <= 1'b1;
            wptr          <= '0;
            busy_r        <= 1'b0;
            done_o        <= 1'b0;
        end else begin
            command_nop_d <= (lane_command_i == replica_pkg::NOP);
            if (out_valid) begin
                wptr <= last_wr ? '0 : wptr + 1'b1;    // Wrap ends the pass.
            end
            if (lane_command_i != replica_pkg::NOP) begin
                busy_r <= 1'b1;
            end else if (last_wr) begin
                busy_r <= 1'b0;
            end
            done_o <= last_wr;
        end
    end

endmodule

//--- source/route_readback.sv
`timescale 1ns/1ns

module route_readback #(
    parameter  int NUM_REPLICAS = 4,
    localparam int RW           = (NUM_REPLICAS > 1) ? $clog2(NUM_REPLICAS) : 1
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     rd_i,
    input  logic [RW-1:0]            rd_replica_i,
    input  replica_pkg::route_word_t lane_rd_data_i [NUM_REPLICAS],
    output logic                     rd_valid_o,
    output replica_pkg::route_word_t rd_data_o
);

    logic          rd_d;
    logic [RW-1:0] replica_d;

    // First cycle covers the memory read in the lanes.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_d       <= 1'b0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_d       <= rd_i;
            rd_valid_o <= rd_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_i) begin
            replica_d <= rd_replica_i;
        end
        if (rd_d) begin
            for (int g = 0; g < NUM_REPLICAS; g++) begin
                if (replica_d == RW'(g)) begin
                    rd_data_o <= lane_rd_data_i[g];
                end
            end
        end
    end

endmodule

//--- source/route_anneal_top.sv
`timescale 1ns/1ns

module route_anneal_top #(
    parameter  int NUM_REPLICAS = 4,
    parameter  int CITY_NUM     = 64,
    localparam int WORDS        = CITY_NUM / replica_pkg::cities_per_word,
    localparam int AW           = (WORDS > 1) ? $clog2(WORDS) : 1,
    localparam int RW           = (NUM_REPLICAS > 1) ? $clog2(NUM_REPLICAS) : 1
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     move_i,
    input  logic [RW-1:0]            move_replica_i,
    input  replica_pkg::command_t    move_command_i,
    input  replica_pkg::pos_t        move_k_i,
    input  replica_pkg::pos_t        move_l_i,
    input  logic                     load_i,
    input  logic [RW-1:0]            load_replica_i,
    input  logic [AW-1:0]            load_addr_i,
    input  replica_pkg::route_word_t load_data_i,
    input  logic                     rd_i,
    input  logic [RW-1:0]            rd_replica_i,
    input  logic [AW-1:0]            rd_addr_i,
    output logic [NUM_REPLICAS-1:0]  busy_o,
    output logic [NUM_REPLICAS-1:0]  done_o,
    output logic                     rd_valid_o,
    output replica_pkg::route_word_t rd_data_o
);

    replica_pkg::command_t    lane_command [NUM_REPLICAS];
    replica_pkg::command_t    opt_command  [NUM_REPLICAS];
    replica_pkg::pos_t        opt_k        [NUM_REPLICAS];
    replica_pkg::pos_t        opt_l        [NUM_REPLICAS];
    replica_pkg::route_word_t lane_rd_data [NUM_REPLICAS];
    logic [NUM_REPLICAS-1:0]  lane_load;

    move_dispatch #(
        .NUM_REPLICAS (NUM_REPLICAS)
    ) u_dispatch (
        .clk            (clk),
        .reset          (reset),
        .move_i         (move_i),
        .move_replica_i (move_replica_i),
        .move_command_i (move_command_i),
        .move_k_i       (move_k_i),
        .move_l_i       (move_l_i),
        .lane_busy_i    (busy_o),
        .lane_command_o (lane_command),
        .opt_command_o  (opt_command),
        .opt_k_o        (opt_k),
        .opt_l_o        (opt_l)
    );

    // ****************************************
    // Replica lanes
    // ****************************************

    for (genvar g = 0; g < NUM_REPLICAS; g++) begin : g_lane
        // Loads are dropped while any lane runs a pass.
        assign lane_load[g] = load_i && (load_replica_i == RW'(g)) && (busy_o == '0);

        route_lane #(
            .CITY_NUM (CITY_NUM)
        ) u_lane (
            .clk            (clk),
            .reset          (reset),
            .lane_command_i (lane_command[g]),
            .opt_command_i  (opt_command[g]),
            .opt_k_i        (opt_k[g]),
            .opt_l_i        (opt_l[g]),
            .load_i         (lane_load[g]),
            .load_addr_i    (load_addr_i),
            .load_data_i    (load_data_i),
            .host_rd_addr_i (rd_addr_i),
            .busy_o         (busy_o[g]),
            .done_o         (done_o[g]),
            .host_rd_data_o (lane_rd_data[g])
        );
    end

    route_readback #(
        .NUM_REPLICAS (NUM_REPLICAS)
    ) u_readback (
        .clk            (clk),
        .reset          (reset),
        .rd_i           (rd_i),
        .rd_replica_i   (rd_replica_i),
        .lane_rd_data_i (lane_rd_data),
        .rd_valid_o     (rd_valid_o),
        .rd_data_o      (rd_data_o)
    );

endmodule

//--- testbench/route_anneal_props.sv
`timescale 1ns/1ns

module route_anneal_props (
    input logic                  clk,
    input logic                  reset,
    input replica_pkg::command_t lane_command_i,
    input logic                  load_i,
    input logic                  busy_r_i,
    input logic                  busy_i,
    input logic                  done_i
);

    // ****************************************
    // Lane protocol
    // ****************************************

    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        done_i |=> !done_i)
        else $error("done_o stayed high for more than one cycle");

    busy_needs_command: assert property (@(posedge clk) disable iff (reset)
        $rose(busy_i) |-> (lane_command_i != replica_pkg::NOP))
        else $error("busy_o rose without a command pulse");

    command_when_idle: assert property (@(posedge clk) disable iff (reset)
        (lane_command_i != replica_pkg::NOP) |-> !busy_r_i)
        else $error("A command reached a lane that was still busy");

    load_when_idle: assert property (@(posedge clk) disable iff (reset)
        load_i |-> !busy_i)
        else $error("A tour load reached a busy lane");

endmodule

//--- testbench/route_anneal_tb.sv
`timescale 1ns/1ns

module route_anneal_tb;

    localparam int num_replicas   = 4;
    localparam int city_num       = 64;
    localparam int cpw            = replica_pkg::cities_per_word;
    localparam int words          = city_num / cpw;
    localparam int aw             = $clog2(words);
    localparam int rw             = $clog2(num_replicas);
    localparam int num_moves      = 11;
    localparam int timeout_cycles = num_moves * (city_num / 8 + 10) + 1000;

    typedef struct packed {
        int                    replica;
        replica_pkg::command_t command;
        int                    k;
        int                    l;
    } move_t;

    // Replica, command, K, L.
    move_t moves [num_moves] = '{
        '{0, replica_pkg::THR, 0, 0},
        '{1, replica_pkg::OR0, 3, 6},      // Same word.
        '{2, replica_pkg::OR0, 0, 63},     // First to last position.
        '{3, replica_pkg::OR0, 5, 40},
        '{0, replica_pkg::OR0, 7, 8},      // Across a word edge.
        '{1, replica_pkg::OR0, 60, 63},    // Last word.
        '{2, replica_pkg::OR0, 17, 18},
        '{3, replica_pkg::THR, 0, 0},
        '{0, replica_pkg::OR0, 0, 7},
        '{1, replica_pkg::OR0, 12, 50},
        '{2, replica_pkg::OR0, 56, 57}
    };

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     move;
    logic                     load;
    logic                     rd;
    logic [rw-1:0]            move_replica;
    logic [rw-1:0]            load_replica;
    logic [rw-1:0]            rd_replica;
    logic [aw-1:0]            load_addr;
    logic [aw-1:0]            rd_addr;
    replica_pkg::command_t    move_command;
    replica_pkg::pos_t        move_k;
    replica_pkg::pos_t        move_l;
    replica_pkg::route_word_t load_data;
    logic [num_replicas-1:0]  busy;
    logic [num_replicas-1:0]  done;
    logic                     rd_valid;
    replica_pkg::route_word_t rd_data;

    int model [num_replicas][city_num];
    int done_count [num_replicas];
    int expected_done [num_replicas];
    int cycle_count = 0;

    route_anneal_top #(
        .NUM_REPLICAS (num_replicas),
        .CITY_NUM     (city_num)
    ) dut0 (
        .clk            (clk),
        .reset          (reset),
        .move_i         (move),
        .move_replica_i (move_replica),
        .move_command_i (move_command),
        .move_k_i       (move_k),
        .move_l_i       (move_l),
        .load_i         (load),
        .load_replica_i (load_replica),
        .load_addr_i    (load_addr),
        .load_data_i    (load_data),
        .rd_i           (rd),
        .rd_replica_i   (rd_replica),
        .rd_addr_i      (rd_addr),
        .busy_o         (busy),
        .done_o         (done),
        .rd_valid_o     (rd_valid),
        .rd_data_o      (rd_data)
    );

    bind route_lane route_anneal_props u_props (
        .clk            (clk),
        .reset          (reset),
        .lane_command_i (lane_command_i),
        .load_i         (load_i),
        .busy_r_i       (busy_r),
        .busy_i         (busy_o),
        .done_i         (done_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        for (int r = 0; r < num_replicas; r++) begin
            if (reset) begin
                done_count[r] <= 0;
            end else if (done[r]) begin
                done_count[r] <= done_count[r] + 1;    // Pulses per lane.
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not end within %0d cycles", timeout_cycles);
            $display("TESTS FAILED");
            $fatal(1, "Run stopped by the cycle limit.");
        end
    end

    // ****************************************
    // Checks and reference model
    // ****************************************

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual,
                     expected);
            $display("TESTS FAILED");
            $fatal(1, "Stopped at the first error.");
        end
    endtask

    function automatic replica_pkg::route_word_t model_word(int r, int w);
        replica_pkg::route_word_t word;
        for (int i = 0; i < cpw; i++) begin
            word[i] = replica_pkg::city_t'(model[r][w * cpw + i]);    // Slot i is 8w+i.
        end
        return word;
    endfunction

    task automatic update_model(move_t m);
        int moved;
        if (m.command == replica_pkg::OR0) begin
            moved = model[m.replica][m.k];
            for (int i = m.k; i < m.l; i++) begin
                model[m.replica][i] = model[m.replica][i + 1];
            end
            model[m.replica][m.l] = moved;
        end
    endtask

    task automatic shuffle_tours();
        int j;
        int t;
        for (int r = 0; r < num_replicas; r++) begin
            for (int i = 0; i < city_num; i++) begin
                model[r][i] = i;
            end
            for (int i = city_num - 1; i > 0; i--) begin
                j = int'($urandom % 32'(i + 1));
                t = model[r][i];
                model[r][i] = model[r][j];
                model[r][j] = t;
            end
        end
    endtask

    // ****************************************
    // Host bus tasks
    // ****************************************

    task automatic load_tours();
        for (int r = 0; r < num_replicas; r++) begin
            for (int w = 0; w < words; w++) begin
                load         = 1'b1;
                load_replica = rw'(r);
                load_addr    = aw'(w);
                load_data    = model_word(r, w);
                @(negedge clk);
            end
        end
        load = 1'b0;
    endtask

    // Valid must come exactly two cycles after the strobe.
    task automatic read_word(int r, int w);
        rd         = 1'b1;
        rd_replica = rw'(r);
        rd_addr    = aw'(w);
        @(negedge clk);
        rd = 1'b0;
        check_value(64'(rd_valid), 64'(0), "rd_valid_o one cycle after rd_i");
        @(negedge clk);
        check_value(64'(rd_valid), 64'(1), "rd_valid_o two cycles after rd_i");
        check_value(64'(rd_data), 64'(model_word(r, w)),
                    $sformatf("replica %0d word %0d", r, w));
    endtask

    task automatic read_tour(int r);
        for (int w = 0; w < words; w++) begin
            read_word(r, w);
        end
    endtask

    task automatic run_move(move_t m);
        move         = 1'b1;
        move_replica = rw'(m.replica);
        move_command = m.command;
        move_k       = replica_pkg::pos_t'(m.k);
        move_l       = replica_pkg::pos_t'(m.l);
        @(negedge clk);
        move = 1'b0;
        check_value(64'(busy[m.replica]), 64'(1), "busy_o in the command cycle");
        do begin
            @(negedge clk);
        end while (!done[m.replica]);
        check_value(64'(done), 64'(1) << m.replica, "done_o lanes at the end of a pass");
        check_value(64'(busy), 64'(0), "busy_o together with done_o");
        expected_done[m.replica]++;
        update_model(m);
    endtask

    // ****************************************
    // Main sequence
    // ****************************************

    initial begin
        void'($urandom(32'h7be9_b6a6));
        reset        = 1'b1;
        move         = 1'b0;
        move_replica = '0;
        move_command = replica_pkg::NOP;
        move_k       = '0;
        move_l       = '0;
        load         = 1'b0;
        load_replica = '0;
        load_addr    = '0;
        load_data    = '0;
        rd           = 1'b0;
        rd_replica   = '0;
        rd_addr      = '0;
        for (int r = 0; r < num_replicas; r++) begin
            expected_done[r] = 0;
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;

        shuffle_tours();
        load_tours();
        for (int r = 0; r < num_replicas; r++) begin
            read_tour(r);
        end
        for (int n = 0; n < num_moves; n++) begin
            run_move(moves[n]);
            read_tour(moves[n].replica);
        end
        for (int r = 0; r < num_replicas; r++) begin
            read_tour(r);    // Other lanes must be untouched.
            check_value(64'(done_count[r]), 64'(expected_done[r]),
                        $sformatf("done_o pulse count of replica %0d", r));
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- route_opt.f
source/replica_pkg.sv
source/move_dispatch.sv
source/route_store.sv
source/opt_route.sv
source/route_lane.sv
source/route_readback.sv
source/route_anneal_top.sv
testbench/route_anneal_props.sv
testbench/route_anneal_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the route annealer testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f route_opt.f \
    --top-module route_anneal_tb -Mdir obj_dir -o route_anneal_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/route_anneal_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$log"; then
    exit 1
fi
exit 0
